// File: design/enet_pkg.sv
`default_nettype none

package enet_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // coalescing fields of TXIC/RXIC
    typedef logic [7:0]  ic_count_t;
    typedef logic [15:0] ic_timer_t;

    // MDC half period in clk cycles
    typedef logic [5:0]  mii_speed_t;

    localparam csr_addr_t EIR_ADDR  = 12'h004;
    localparam csr_addr_t EIMR_ADDR = 12'h008;
    localparam csr_addr_t ECR_ADDR  = 12'h024;
    localparam csr_addr_t MMFR_ADDR = 12'h040;
    localparam csr_addr_t MSCR_ADDR = 12'h044;
    localparam csr_addr_t TXIC_ADDR = 12'h0F0;
    localparam csr_addr_t RXIC_ADDR = 12'h100;

    localparam int EIR_TXF     = 27;
    localparam int EIR_RXF     = 25;
    localparam int EIR_MII     = 23;
    localparam int ECR_ETHEREN = 1;
    localparam int IC_ICEN     = 31;

    // txf, rxf and mii
    localparam csr_data_t EIR_MASK  = 32'h0A80_0000;
    localparam csr_data_t EIMR_MASK = 32'h0A80_0000;
    localparam csr_data_t ECR_MASK  = 32'h0000_0002;
    localparam csr_data_t MSCR_MASK = 32'h0000_007E;
    // icen, icft and ictt
    localparam csr_data_t IC_MASK   = 32'h8FF0_FFFF;

    localparam int MDIO_PRE_BITS        = 32;
    localparam int MDIO_FRAME_BITS      = 32;
    // st, op, pa and ra are driven by the master on a read
    localparam int MDIO_READ_DRIVE_BITS = 14;
    localparam logic [1:0] MDIO_OP_READ = 2'b10;

    typedef enum logic [1:0] {
        mdio_idle,
        mdio_preamble,
        mdio_frame,
        mdio_done
    } mdio_state_e;

    typedef enum logic {
        coal_idle,
        coal_counting
    } coal_state_e;

endpackage

`default_nettype wire

// File: design/enet_csr_if.sv
`default_nettype none

interface enet_csr_if import enet_pkg::*; ();

    csr_data_t wdata;
    logic      ecr_wen;
    logic      eir_wen;
    logic      eimr_wen;
    logic      mmfr_wen;
    logic      mscr_wen;
    logic      txic_wen;
    logic      rxic_wen;
    logic      ether_en;

    modport decode (
        output wdata, ecr_wen, eir_wen, eimr_wen, mmfr_wen,
        output mscr_wen, txic_wen, rxic_wen, ether_en
    );

    modport sink (
        input wdata, ecr_wen, eir_wen, eimr_wen, mmfr_wen,
        input mscr_wen, txic_wen, rxic_wen, ether_en
    );

endinterface

`default_nettype wire

// File: design/enet_csr_decode.sv
`default_nettype none

module enet_csr_decode import enet_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              reg_wen,
    input  logic              reg_ren,
    input  csr_addr_t         reg_addr,
    input  csr_data_t         reg_wdata,
    output csr_data_t         reg_rdata,
    enet_csr_if.decode        csr,
    input  csr_data_t         eir,
    input  csr_data_t         eimr,
    input  csr_data_t         mmfr,
    input  csr_data_t         mscr,
    input  csr_data_t         txic,
    input  csr_data_t         rxic
);

    csr_data_t ecr;
    csr_data_t rd_mux;

    // one write strobe per register, qualified by reg_wen
    assign csr.wdata    = reg_wdata;
    assign csr.ecr_wen  = reg_wen && (reg_addr == ECR_ADDR);
    assign csr.eir_wen  = reg_wen && (reg_addr == EIR_ADDR);
    assign csr.eimr_wen = reg_wen && (reg_addr == EIMR_ADDR);
    assign csr.mmfr_wen = reg_wen && (reg_addr == MMFR_ADDR);
    assign csr.mscr_wen = reg_wen && (reg_addr == MSCR_ADDR);
    assign csr.txic_wen = reg_wen && (reg_addr == TXIC_ADDR);
    assign csr.rxic_wen = reg_wen && (reg_addr == RXIC_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            ecr <= '0;
        end else if (csr.ecr_wen) begin
            ecr <= reg_wdata & ECR_MASK;
        end
    end

    assign csr.ether_en = ecr[ECR_ETHEREN];

    always_comb begin
        case (reg_addr)
            EIR_ADDR:  rd_mux = eir;
            EIMR_ADDR: rd_mux = eimr;
            ECR_ADDR:  rd_mux = ecr;
            MMFR_ADDR: rd_mux = mmfr;
            MSCR_ADDR: rd_mux = mscr;
            TXIC_ADDR: rd_mux = txic;
            RXIC_ADDR: rd_mux = rxic;
            // unmapped offsets read as zero
            default:   rd_mux = '0;
        endcase
    end

    // read data holds until the next read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_ren) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: design/enet_intr_coalesce.sv
`default_nettype none

module enet_intr_coalesce import enet_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    enet_csr_if.sink        csr,
    input  logic            cfg_wen,
    input  logic            frame_done,
    output csr_data_t       cfg,
    output logic            frame_intr
);

    coal_state_e state;
    ic_count_t   frame_cnt;
    ic_count_t   cnt_next;
    ic_count_t   icft;
    ic_count_t   ft_eff;
    ic_timer_t   timer;
    ic_timer_t   timer_next;
    ic_timer_t   ictt;
    logic        icen;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (cfg_wen) begin
            cfg <= csr.wdata & IC_MASK;
        end
    end

    assign icen = cfg[IC_ICEN];
    assign icft = cfg[27:20];
    assign ictt = cfg[15:0];

    // a frame threshold of zero behaves like one
    assign ft_eff     = (icft == '0) ? ic_count_t'(1) : icft;
    assign cnt_next   = frame_cnt + ic_count_t'(frame_done);
    assign timer_next = timer + ic_timer_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= coal_idle;
            frame_cnt  <= '0;
            timer      <= '0;
            frame_intr <= 1'b0;
        end else if (!csr.ether_en || !icen) begin
            // bypass passes each frame on one cycle later
            state      <= coal_idle;
            frame_cnt  <= '0;
            timer      <= '0;
            frame_intr <= csr.ether_en && frame_done;
        end else begin
            frame_intr <= 1'b0;
            case (state)
                coal_idle: begin
                    if (frame_done) begin
                        if (cnt_next >= ft_eff) begin
                            frame_intr <= 1'b1;
                        end else begin
                            state     <= coal_counting;
                            frame_cnt <= cnt_next;
                            timer     <= '0;
                        end
                    end
                end
                coal_counting: begin
                    // fire on count or timeout, whichever comes first
                    if (cnt_next >= ft_eff || timer_next >= ictt) begin
                        frame_intr <= 1'b1;
                        state      <= coal_idle;
                        frame_cnt  <= '0;
                        timer      <= '0;
                    end else begin
                        frame_cnt <= cnt_next;
                        timer     <= timer_next;
                    end
                end
                default: begin
                    state <= coal_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/enet_mdio_master.sv
`default_nettype none

module enet_mdio_master import enet_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    enet_csr_if.sink        csr,
    input  logic            mdi,
    output csr_data_t       mmfr,
    output csr_data_t       mscr,
    output logic            mdc,
    output logic            mdo,
    output logic            mdo_en,
    output logic            mii_done
);

    mdio_state_e state;
    mii_speed_t  mii_speed;
    mii_speed_t  speed_q;
    mii_speed_t  div_cnt;
    logic [5:0]  bit_cnt;
    csr_data_t   shift_q;
    logic        rd_op;
    logic        mdc_edge;
    logic        start;

    assign mii_speed = mscr[6:1];
    assign start     = csr.mmfr_wen && csr.ether_en && (mii_speed != '0)
                       && (state == mdio_idle);
    assign mdc_edge  = (div_cnt == speed_q - mii_speed_t'(1));
    assign mii_done  = (state == mdio_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            mscr <= '0;
        end else if (csr.mscr_wen) begin
            mscr <= csr.wdata & MSCR_MASK;
        end
    end

    // mmfr takes bus writes, and read data is shifted into its low half
    always_ff @(posedge clk) begin
        if (rst) begin
            mmfr <= '0;
        end else if (csr.mmfr_wen) begin
            mmfr <= csr.wdata;
        end else if (state == mdio_frame && mdc_edge && !mdc && rd_op
                     && bit_cnt >= 6'(MDIO_FRAME_BITS - 16)) begin
            mmfr[15:0] <= {mmfr[14:0], mdi};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mdio_idle;
            speed_q <= '0;
            div_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= '0;
            rd_op   <= 1'b0;
            mdc     <= 1'b0;
            mdo     <= 1'b0;
            mdo_en  <= 1'b0;
        end else if (!csr.ether_en) begin
            state  <= mdio_idle;
            mdc    <= 1'b0;
            mdo    <= 1'b0;
            mdo_en <= 1'b0;
        end else begin
            case (state)
                mdio_idle: begin
                    if (start) begin
                        state   <= mdio_preamble;
                        speed_q <= mii_speed;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        shift_q <= csr.wdata;
                        rd_op   <= (csr.wdata[29:28] == MDIO_OP_READ);
                        mdc     <= 1'b0;
                        mdo     <= 1'b1;
                        mdo_en  <= 1'b1;
                    end
                end
                mdio_preamble, mdio_frame: begin
                    if (!mdc_edge) begin
                        div_cnt <= div_cnt + mii_speed_t'(1);
                    end else begin
                        div_cnt <= '0;
                        mdc     <= !mdc;
                        // next bit goes out after the falling edge
                        if (mdc) begin
                            if (state == mdio_preamble) begin
                                if (bit_cnt == 6'(MDIO_PRE_BITS - 1)) begin
                                    state   <= mdio_frame;
                                    bit_cnt <= '0;
                                    mdo     <= shift_q[31];
                                end else begin
                                    bit_cnt <= bit_cnt + 6'd1;
                                end
                            end else if (bit_cnt == 6'(MDIO_FRAME_BITS - 1)) begin
                                state  <= mdio_done;
                                mdo    <= 1'b0;
                                mdo_en <= 1'b0;
                            end else begin
                                bit_cnt <= bit_cnt + 6'd1;
                                shift_q <= {shift_q[30:0], 1'b0};
                                mdo     <= shift_q[30];
                                // phy owns the line from turnaround on
                                mdo_en  <= !(rd_op && (bit_cnt + 6'd1
                                             >= 6'(MDIO_READ_DRIVE_BITS)));
                            end
                        end
                    end
                end
                mdio_done: begin
                    state <= mdio_idle;
                end
                default: begin
                    state <= mdio_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/enet_event_reg.sv
`default_nettype none

module enet_event_reg import enet_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    enet_csr_if.sink        csr,
    input  logic            txf,
    input  logic            rxf,
    input  logic            mii_done,
    output csr_data_t       eir,
    output csr_data_t       eimr,
    output logic            irq
);

    csr_data_t eir_set;
    csr_data_t eir_clr;

    always_comb begin
        eir_set          = '0;
        eir_set[EIR_TXF] = txf;
        eir_set[EIR_RXF] = rxf;
        eir_set[EIR_MII] = mii_done;
    end

    // write 1 to clear
    assign eir_clr = csr.eir_wen ? (csr.wdata & EIR_MASK) : '0;

    // a new event in the clearing cycle keeps its bit set
    always_ff @(posedge clk) begin
        if (rst) begin
            eir <= '0;
        end else begin
            eir <= (eir & ~eir_clr) | eir_set;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eimr <= '0;
        end else if (csr.eimr_wen) begin
            eimr <= csr.wdata & EIMR_MASK;
        end
    end

    assign irq = |(eir & eimr);

endmodule

`default_nettype wire

// File: design/enet_intr_core.sv
`default_nettype none

module enet_intr_core import enet_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            reg_wen,
    input  logic            reg_ren,
    input  csr_addr_t       reg_addr,
    input  csr_data_t       reg_wdata,
    output csr_data_t       reg_rdata,
    input  logic            tx_frame_done,
    input  logic            rx_frame_done,
    output logic            mdc,
    input  logic            mdi,
    output logic            mdo,
    output logic            mdo_en,
    output logic            irq
);

    csr_data_t eir;
    csr_data_t eimr;
    csr_data_t mmfr;
    csr_data_t mscr;
    csr_data_t txic;
    csr_data_t rxic;
    logic      txf;
    logic      rxf;
    logic      mii_done;

    enet_csr_if csr_bus ();

    enet_csr_decode u_csr_decode (
        .clk        (clk        ),
        .rst        (rst        ),
        .reg_wen    (reg_wen    ),
        .reg_ren    (reg_ren    ),
        .reg_addr   (reg_addr   ),
        .reg_wdata  (reg_wdata  ),
        .reg_rdata  (reg_rdata  ),
        .csr        (csr_bus    ),
        .eir        (eir        ),
        .eimr       (eimr       ),
        .mmfr       (mmfr       ),
        .mscr       (mscr       ),
        .txic       (txic       ),
        .rxic       (rxic       )
    );

    enet_intr_coalesce u_tx_coalesce (
        .clk        (clk                ),
        .rst        (rst                ),
        .csr        (csr_bus            ),
        .cfg_wen    (csr_bus.txic_wen   ),
        .frame_done (tx_frame_done      ),
        .cfg        (txic               ),
        .frame_intr (txf                )
    );

    enet_intr_coalesce u_rx_coalesce (
        .clk        (clk                ),
        .rst        (rst                ),
        .csr        (csr_bus            ),
        .cfg_wen    (csr_bus.rxic_wen   ),
        .frame_done (rx_frame_done      ),
        .cfg        (rxic               ),
        .frame_intr (rxf                )
    );

    enet_mdio_master u_mdio_master (
        .clk        (clk        ),
        .rst        (rst        ),
        .csr        (csr_bus    ),
        .mdi        (mdi        ),
        .mmfr       (mmfr       ),
        .mscr       (mscr       ),
        .mdc        (mdc        ),
        .mdo        (mdo        ),
        .mdo_en     (mdo_en     ),
        .mii_done   (mii_done   )
    );

    enet_event_reg u_event_reg (
        .clk        (clk        ),
        .rst        (rst        ),
        .csr        (csr_bus    ),
        .txf        (txf        ),
        .rxf        (rxf        ),
        .mii_done   (mii_done   ),
        .eir        (eir        ),
        .eimr       (eimr       ),
        .irq        (irq        )
    );

endmodule

`default_nettype wire

// File: testbench/tb_enet_intr_core.sv
`default_nettype none

module tb_enet_intr_core import enet_pkg::*; ();

    // mdio frames, coalescing timers and register loops, with margin
    localparam int CYCLE_LIMIT = 40000;

    logic      clk;
    logic      rst;
    logic      reg_wen;
    logic      reg_ren;
    csr_addr_t reg_addr;
    csr_data_t reg_wdata;
    csr_data_t reg_rdata;
    logic      tx_frame_done;
    logic      rx_frame_done;
    logic      mdc;
    logic      mdi;
    logic      mdo;
    logic      mdo_en;
    logic      irq;

    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state;

    // register model
    csr_data_t m_ecr;
    csr_data_t m_eir;
    csr_data_t m_eimr;
    csr_data_t m_mmfr;
    csr_data_t m_mscr;
    csr_data_t m_txic;
    csr_data_t m_rxic;

    enet_intr_core enet_intr_core_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic csr_data_t expected_reg(input csr_addr_t addr);
        case (addr)
            EIR_ADDR:  return m_eir;
            EIMR_ADDR: return m_eimr;
            ECR_ADDR:  return m_ecr;
            MMFR_ADDR: return m_mmfr;
            MSCR_ADDR: return m_mscr;
            TXIC_ADDR: return m_txic;
            RXIC_ADDR: return m_rxic;
            default:   return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input csr_data_t expected,
                               input csr_data_t actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
        reg_addr = addr;
        reg_wdata = data;
        reg_wen = 1'b1;
        step_cycle();
        reg_wen = 1'b0;
        case (addr)
            ECR_ADDR:  m_ecr = data & ECR_MASK;
            EIMR_ADDR: m_eimr = data & EIMR_MASK;
            MSCR_ADDR: m_mscr = data & MSCR_MASK;
            TXIC_ADDR: m_txic = data & IC_MASK;
            RXIC_ADDR: m_rxic = data & IC_MASK;
            MMFR_ADDR: m_mmfr = data;
            // write 1 to clear
            EIR_ADDR:  m_eir = m_eir & ~(data & EIR_MASK);
            default: ;
        endcase
    endtask

    task automatic check_reg(input string name, input csr_addr_t addr);
        reg_addr = addr;
        reg_ren = 1'b1;
        step_cycle();
        reg_ren = 1'b0;
        check_value(name, expected_reg(addr), reg_rdata);
    endtask

    task automatic pulse_frame(input logic tx, input logic rx);
        tx_frame_done = tx;
        rx_frame_done = rx;
        step_cycle();
        tx_frame_done = 1'b0;
        rx_frame_done = 1'b0;
    endtask

    task automatic wait_for_irq(input string name, input int limit);
        int n;
        n = 0;
        while (!irq && n < limit) begin
            step_cycle();
            n++;
        end
        if (!irq) begin
            $display("%s: irq did not rise within %0d cycles", name, limit);
            errors++;
        end
    endtask

    task automatic test_readback();
        logic [31:0] r;
        csr_addr_t   addr;
        for (int i = 0; i < 30; i++) begin
            r = next_random();
            case (r % 5)
                0:       addr = ECR_ADDR;
                1:       addr = EIMR_ADDR;
                2:       addr = MSCR_ADDR;
                3:       addr = TXIC_ADDR;
                default: addr = RXIC_ADDR;
            endcase
            write_reg(addr, next_random());
            check_reg($sformatf("readback %h", addr), addr);
        end
        // mostly unmapped offsets
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            check_reg($sformatf("read of %h", r[11:0]), r[11:0]);
        end
    endtask

    task automatic test_events();
        logic [31:0] r;
        write_reg(ECR_ADDR, 32'h2);
        write_reg(TXIC_ADDR, 32'h0);
        write_reg(RXIC_ADDR, 32'h0);
        for (int i = 0; i < 16; i++) begin
            r = next_random();
            pulse_frame(r[0], r[1]);
            m_eir[EIR_TXF] = m_eir[EIR_TXF] | r[0];
            m_eir[EIR_RXF] = m_eir[EIR_RXF] | r[1];
            repeat (2) step_cycle();
            check_reg("eir after frames", EIR_ADDR);
            write_reg(EIMR_ADDR, next_random());
            check_value("irq", 32'(|(m_eir & m_eimr)), 32'(irq));
            write_reg(EIR_ADDR, next_random());
            check_reg("eir after clear", EIR_ADDR);
        end
        write_reg(EIR_ADDR, EIR_MASK);
        write_reg(ECR_ADDR, 32'h0);
        pulse_frame(1'b1, 1'b1);
        repeat (3) step_cycle();
        check_reg("eir with ether_en low", EIR_ADDR);
        write_reg(ECR_ADDR, 32'h2);
    endtask

    task automatic test_coalesce_count(input logic is_tx);
        int        n;
        csr_addr_t cfg_addr;
        csr_data_t evt;
        string     name;
        n = 2 + int'(next_random() % 7);
        cfg_addr = is_tx ? TXIC_ADDR : RXIC_ADDR;
        evt = csr_data_t'(1) << (is_tx ? EIR_TXF : EIR_RXF);
        name = is_tx ? "tx count" : "rx count";
        write_reg(cfg_addr, 32'h8000_FFFF | (csr_data_t'(n) << 20));
        write_reg(EIMR_ADDR, evt);
        repeat (n - 1) begin
            pulse_frame(is_tx, !is_tx);
            repeat (int'(next_random() % 3)) step_cycle();
        end
        repeat (3) step_cycle();
        check_reg({name, " below threshold"}, EIR_ADDR);
        pulse_frame(is_tx, !is_tx);
        m_eir = m_eir | evt;
        wait_for_irq(name, 10);
        check_reg({name, " at threshold"}, EIR_ADDR);
        write_reg(EIR_ADDR, EIR_MASK);
        write_reg(cfg_addr, 32'h0);
    endtask

    task automatic test_coalesce_timer();
        int t;
        t = 20 + int'(next_random() % 181);
        write_reg(RXIC_ADDR, 32'h8FF0_0000 | csr_data_t'(t));
        write_reg(EIMR_ADDR, csr_data_t'(1) << EIR_RXF);
        pulse_frame(1'b0, 1'b1);
        repeat (t / 2) step_cycle();
        check_reg("rx timer early", EIR_ADDR);
        m_eir[EIR_RXF] = 1'b1;
        wait_for_irq("rx timer", 2 * t + 4 - t / 2 - 1);
        check_reg("rx timer expired", EIR_ADDR);
        write_reg(EIR_ADDR, EIR_MASK);
        write_reg(RXIC_ADDR, 32'h0);
    endtask

    task automatic run_mdio_frame(input logic is_read);
        logic [31:0] r;
        csr_data_t   frame;
        logic [15:0] rd_bits;
        logic [15:0] rd_shift;
        logic [63:0] seen;
        logic        mdc_prev;
        int          speed;
        int          edges;
        int          waited;
        int          hold;
        speed = 1 + int'(next_random() % 8);
        frame = next_random();
        frame[29:28] = is_read ? MDIO_OP_READ : 2'b01;
        r = next_random();
        rd_bits = r[15:0];
        rd_shift = rd_bits;
        seen = '0;
        write_reg(MSCR_ADDR, csr_data_t'(speed) << 1);
        write_reg(EIMR_ADDR, csr_data_t'(1) << EIR_MII);
        write_reg(MMFR_ADDR, frame);
        mdc_prev = mdc;
        edges = 0;
        waited = 0;
        hold = 0;
        while (edges < 64 && waited < 64 * 2 * speed + 16) begin
            step_cycle();
            waited++;
            hold++;
            // each MDC level lasts MII_SPEED clk cycles
            if (mdc !== mdc_prev) begin
                check_value("mdc half period", csr_data_t'(speed), csr_data_t'(hold));
                hold = 0;
            end
            if (mdc && !mdc_prev) begin
                seen = {seen[62:0], mdo};
                // on a read the phy drives from bit 14 of the frame on
                check_value("mdo_en", 32'(!is_read || edges < 46), 32'(mdo_en));
                edges++;
                if (is_read && edges >= 48 && edges < 64) begin
                    mdi = rd_shift[15];
                    rd_shift = rd_shift << 1;
                end
            end
            mdc_prev = mdc;
        end
        mdi = 1'b0;
        if (edges < 64) begin
            $display("mdio frame stopped after %0d of 64 MDC rising edges", edges);
            errors++;
        end
        check_value("mdio preamble", 32'hFFFF_FFFF, seen[63:32]);
        if (is_read) begin
            check_value("mdio read header", frame & 32'hFFFC_0000,
                        seen[31:0] & 32'hFFFC_0000);
            m_mmfr[15:0] = rd_bits;
        end else begin
            check_value("mdio write bits", frame, seen[31:0]);
        end
        m_eir[EIR_MII] = 1'b1;
        wait_for_irq("mdio done", 4 * speed + 8);
        check_reg("eir after mdio", EIR_ADDR);
        check_reg("mmfr after mdio", MMFR_ADDR);
        write_reg(EIR_ADDR, EIR_MASK);
    endtask

    initial begin
        rst = 1'b1;
        reg_wen = 1'b0;
        reg_ren = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        tx_frame_done = 1'b0;
        rx_frame_done = 1'b0;
        mdi = 1'b0;
        rng_state = 32'h48f4_21d2;
        m_ecr = '0;
        m_eir = '0;
        m_eimr = '0;
        m_mmfr = '0;
        m_mscr = '0;
        m_txic = '0;
        m_rxic = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_readback();
        test_events();
        test_coalesce_count(1'b1);
        test_coalesce_count(1'b0);
        test_coalesce_timer();
        run_mdio_frame(1'b0);
        run_mdio_frame(1'b0);
        run_mdio_frame(1'b1);
        run_mdio_frame(1'b1);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/enet_pkg.sv
design/enet_csr_if.sv
design/enet_csr_decode.sv
design/enet_intr_coalesce.sv
design/enet_mdio_master.sv
design/enet_event_reg.sv
design/enet_intr_core.sv
testbench/tb_enet_intr_core.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, result taken from sim.log
verilator --binary --top-module tb_enet_intr_core -f flist.f -o tb_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log \
    && { echo "simulation reported a failure, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log \
    || { echo "no result found in sim.log"; exit 1; }
echo "simulation ok"
